//--- hdl/ctrl_settings.svh
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// opcode field width of the instruction register
`define CTRL_OPCODE_WIDTH 8

// extra cycles a data memory access needs beyond the first
`define CTRL_MEM_LATENCY 1

`endif

//--- hdl/ctrlPkg.sv
`default_nettype none

`include "ctrl_settings.svh"

package ctrlPkg;

    typedef enum logic [`CTRL_OPCODE_WIDTH-1:0] {
        NOP      = 'd0,
        ENDOP    = 'd1,
        CLAC     = 'd2,
        LDIAC    = 'd3,
        LDAC     = 'd4,
        STR      = 'd5,
        STIR     = 'd6,
        JUMP     = 'd7,
        JMPNZ    = 'd8,
        JMPZ     = 'd9,
        MUL      = 'd10,
        ADD      = 'd11,
        SUB      = 'd12,
        INCAC    = 'd13,
        MV_RL_AC = 'd14,
        MV_RP_AC = 'd15,
        MV_RQ_AC = 'd16,
        MV_RC_AC = 'd17,
        MV_R_AC  = 'd18,
        MV_R1_AC = 'd19,
        MV_AC_RP = 'd20,
        MV_AC_RQ = 'd21,
        MV_AC_RL = 'd22
    } instrOp_t;

    typedef enum logic [2:0] {
        aluIdle, aluClr, aluPass, aluAdd, aluSub, aluMul, aluInc
    } aluOp_t;

    typedef logic [3:0] incReg_t;   // {PC, RC, RP, RQ}

    localparam incReg_t incNone   = 4'b0000;
    localparam incReg_t incPc     = 4'b1000;
    localparam incReg_t incRcRpRq = 4'b0111;   // pointer walk during MUL

    typedef logic [9:0] wrEnReg_t;  // {AR, R, PC, IR, RL, RC, RP, RQ, R1, AC}

    localparam wrEnReg_t wrEnNone = 10'b00_0000_0000;
    localparam wrEnReg_t wrEnAr   = 10'b10_0000_0000;
    localparam wrEnReg_t wrEnR    = 10'b01_0000_0000;
    localparam wrEnReg_t wrEnPc   = 10'b00_1000_0000;
    localparam wrEnReg_t wrEnIr   = 10'b00_0100_0000;
    localparam wrEnReg_t wrEnRl   = 10'b00_0010_0000;
    localparam wrEnReg_t wrEnRc   = 10'b00_0001_0000;
    localparam wrEnReg_t wrEnRp   = 10'b00_0000_1000;
    localparam wrEnReg_t wrEnRq   = 10'b00_0000_0100;
    localparam wrEnReg_t wrEnR1   = 10'b00_0000_0010;
    localparam wrEnReg_t wrEnAc   = 10'b00_0000_0001;

    typedef enum logic [3:0] {
        busIdle, busDMem, busIr, busAc, busR, busRc, busR1, busRp, busRq, busRl
    } busSel_t;

    // one state for each execute step
    typedef enum logic [4:0] {
        Idle, Fetch, Decode,
        NopExec, ClacExec,
        LdiacOperand, LdiacAddr, LdiacLoad,
        LdacAddr, LdacLoad,
        StrAddr, StrWrite,
        StirOperand, StirAddr, StirWrite,
        JumpLoad, JumpSet, BranchSkip,
        MulExec, AddExec, SubExec, IncacExec,
        MvRlAc, MvRpAc, MvRqAc, MvRcAc, MvRAc, MvR1Ac,
        MvAcRp, MvAcRq, MvAcRl,
        Halt
    } ctrlState_t;

endpackage

`default_nettype wire

//--- hdl/memStepTimer.sv
`default_nettype none

`include "ctrl_settings.svh"

module memStepTimer #(
    parameter int MEM_LATENCY = `CTRL_MEM_LATENCY
) (
    input  logic clk,
    input  logic rstN,
    input  logic memStep,
    output logic memStepLast
);

    localparam logic [2:0] LOAD_VALUE = 3'(MEM_LATENCY);

    logic [2:0] cyclesLeft;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cyclesLeft <= LOAD_VALUE;
        end else if (!memStep || memStepLast) begin
            cyclesLeft <= LOAD_VALUE;          // rearm for the next memory step
        end else begin
            cyclesLeft <= cyclesLeft - 3'd1;
        end
    end

    assign memStepLast = memStep && (cyclesLeft == 3'd0);

endmodule

`default_nettype wire

//--- hdl/instrSequencer.sv
`default_nettype none

module instrSequencer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  ctrlPkg::instrOp_t   instruction,
    input  logic                zOut,
    input  logic                memStepLast,
    output ctrlPkg::ctrlState_t state,
    output logic                memStep,
    output logic                done,
    output logic                ready
);

    ctrlPkg::ctrlState_t stepNext;
    ctrlPkg::ctrlState_t nextState;
    ctrlPkg::ctrlState_t decodeNext;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= ctrlPkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    // states that talk to the data memory
    assign memStep = (state == ctrlPkg::Fetch)        ||
                     (state == ctrlPkg::LdiacOperand) ||
                     (state == ctrlPkg::LdiacLoad)    ||
                     (state == ctrlPkg::LdacLoad)     ||
                     (state == ctrlPkg::StrWrite)     ||
                     (state == ctrlPkg::StirOperand)  ||
                     (state == ctrlPkg::StirWrite)    ||
                     (state == ctrlPkg::JumpLoad);

    // opcode dispatch with the zero flag picking the branch path
    always_comb begin
        case (instruction)
            ctrlPkg::NOP:      decodeNext = ctrlPkg::NopExec;
            ctrlPkg::ENDOP:    decodeNext = ctrlPkg::Halt;
            ctrlPkg::CLAC:     decodeNext = ctrlPkg::ClacExec;
            ctrlPkg::LDIAC:    decodeNext = ctrlPkg::LdiacOperand;
            ctrlPkg::LDAC:     decodeNext = ctrlPkg::LdacAddr;
            ctrlPkg::STR:      decodeNext = ctrlPkg::StrAddr;
            ctrlPkg::STIR:     decodeNext = ctrlPkg::StirOperand;
            ctrlPkg::JUMP:     decodeNext = ctrlPkg::JumpLoad;
            ctrlPkg::JMPNZ:    decodeNext = !zOut ? ctrlPkg::JumpLoad : ctrlPkg::BranchSkip;
            ctrlPkg::JMPZ:     decodeNext = zOut ? ctrlPkg::JumpLoad : ctrlPkg::BranchSkip;
            ctrlPkg::MUL:      decodeNext = ctrlPkg::MulExec;
            ctrlPkg::ADD:      decodeNext = ctrlPkg::AddExec;
            ctrlPkg::SUB:      decodeNext = ctrlPkg::SubExec;
            ctrlPkg::INCAC:    decodeNext = ctrlPkg::IncacExec;
            ctrlPkg::MV_RL_AC: decodeNext = ctrlPkg::MvRlAc;
            ctrlPkg::MV_RP_AC: decodeNext = ctrlPkg::MvRpAc;
            ctrlPkg::MV_RQ_AC: decodeNext = ctrlPkg::MvRqAc;
            ctrlPkg::MV_RC_AC: decodeNext = ctrlPkg::MvRcAc;
            ctrlPkg::MV_R_AC:  decodeNext = ctrlPkg::MvRAc;
            ctrlPkg::MV_R1_AC: decodeNext = ctrlPkg::MvR1Ac;
            ctrlPkg::MV_AC_RP: decodeNext = ctrlPkg::MvAcRp;
            ctrlPkg::MV_AC_RQ: decodeNext = ctrlPkg::MvAcRq;
            ctrlPkg::MV_AC_RL: decodeNext = ctrlPkg::MvAcRl;
            default:           decodeNext = ctrlPkg::Idle;   // unknown opcode
        endcase
    end

    // step order within each instruction
    always_comb begin
        case (state)
            ctrlPkg::Idle:         stepNext = start ? ctrlPkg::Fetch : ctrlPkg::Idle;
            ctrlPkg::Fetch:        stepNext = ctrlPkg::Decode;
            ctrlPkg::Decode:       stepNext = decodeNext;
            ctrlPkg::LdiacOperand: stepNext = ctrlPkg::LdiacAddr;
            ctrlPkg::LdiacAddr:    stepNext = ctrlPkg::LdiacLoad;
            ctrlPkg::LdacAddr:     stepNext = ctrlPkg::LdacLoad;
            ctrlPkg::StrAddr:      stepNext = ctrlPkg::StrWrite;
            ctrlPkg::StirOperand:  stepNext = ctrlPkg::StirAddr;
            ctrlPkg::StirAddr:     stepNext = ctrlPkg::StirWrite;
            ctrlPkg::JumpLoad:     stepNext = ctrlPkg::JumpSet;
            ctrlPkg::Halt:         stepNext = ctrlPkg::Halt;       // held until reset
            default:               stepNext = ctrlPkg::Fetch;      // last step of an instruction
        endcase
    end

    assign nextState = (memStep && !memStepLast) ? state : stepNext;

    assign done  = (state == ctrlPkg::Halt);
    assign ready = (state == ctrlPkg::Idle);

endmodule

`default_nettype wire

//--- hdl/controlDecoder.sv
`default_nettype none

module controlDecoder (
    input  ctrlPkg::ctrlState_t state,
    output ctrlPkg::aluOp_t     aluOp,
    output ctrlPkg::incReg_t    incReg,
    output ctrlPkg::wrEnReg_t   wrEnReg,
    output ctrlPkg::busSel_t    busSel,
    output logic                dataMemWrEn,
    output logic                zWrEn
);

    always_comb begin
        aluOp       = ctrlPkg::aluIdle;   // inactive unless a step says otherwise
        incReg      = ctrlPkg::incNone;
        wrEnReg     = ctrlPkg::wrEnNone;
        busSel      = ctrlPkg::busIdle;
        dataMemWrEn = 1'b0;
        zWrEn       = 1'b0;

        case (state)
            ctrlPkg::Fetch: begin
                wrEnReg = ctrlPkg::wrEnIr;
            end
            ctrlPkg::Decode: begin
                incReg = ctrlPkg::incPc;
                busSel = ctrlPkg::busDMem;
            end
            ctrlPkg::ClacExec: begin
                aluOp   = ctrlPkg::aluClr;
                wrEnReg = ctrlPkg::wrEnAc;
                zWrEn   = 1'b1;
            end
            ctrlPkg::LdiacOperand, ctrlPkg::StirOperand: begin
                wrEnReg = ctrlPkg::wrEnIr;           // operand word into IR
            end
            ctrlPkg::LdiacAddr, ctrlPkg::StirAddr: begin
                incReg  = ctrlPkg::incPc;
                wrEnReg = ctrlPkg::wrEnAr;
                busSel  = ctrlPkg::busIr;
            end
            ctrlPkg::LdiacLoad, ctrlPkg::LdacLoad: begin
                aluOp   = ctrlPkg::aluPass;
                wrEnReg = ctrlPkg::wrEnAc;
                busSel  = ctrlPkg::busDMem;
                zWrEn   = 1'b1;
            end
            ctrlPkg::LdacAddr, ctrlPkg::StrAddr: begin
                wrEnReg = ctrlPkg::wrEnAr;           // AC holds the address
                busSel  = ctrlPkg::busAc;
            end
            ctrlPkg::StrWrite, ctrlPkg::StirWrite: begin
                dataMemWrEn = 1'b1;
            end
            ctrlPkg::JumpLoad: begin
                wrEnReg = ctrlPkg::wrEnIr;
                busSel  = ctrlPkg::busDMem;
            end
            ctrlPkg::JumpSet: begin
                wrEnReg = ctrlPkg::wrEnPc;
                busSel  = ctrlPkg::busIr;
            end
            ctrlPkg::BranchSkip: begin
                incReg = ctrlPkg::incPc;             // step over the target word
            end
            ctrlPkg::MulExec: begin
                aluOp   = ctrlPkg::aluMul;
                incReg  = ctrlPkg::incRcRpRq;
                wrEnReg = ctrlPkg::wrEnAc;
                busSel  = ctrlPkg::busR1;
                zWrEn   = 1'b1;
            end
            ctrlPkg::AddExec: begin
                aluOp   = ctrlPkg::aluAdd;
                wrEnReg = ctrlPkg::wrEnAc;
                busSel  = ctrlPkg::busR;
                zWrEn   = 1'b1;
            end
            ctrlPkg::SubExec: begin
                aluOp   = ctrlPkg::aluSub;
                wrEnReg = ctrlPkg::wrEnAc;
                busSel  = ctrlPkg::busRc;
                zWrEn   = 1'b1;
            end
            ctrlPkg::IncacExec: begin
                aluOp   = ctrlPkg::aluInc;
                wrEnReg = ctrlPkg::wrEnAc;
                zWrEn   = 1'b1;
            end
            ctrlPkg::MvRlAc: begin
                wrEnReg = ctrlPkg::wrEnRl;
                busSel  = ctrlPkg::busAc;
            end
            ctrlPkg::MvRpAc: begin
                wrEnReg = ctrlPkg::wrEnRp;
                busSel  = ctrlPkg::busAc;
            end
            ctrlPkg::MvRqAc: begin
                wrEnReg = ctrlPkg::wrEnRq;
                busSel  = ctrlPkg::busAc;
            end
            ctrlPkg::MvRcAc: begin
                wrEnReg = ctrlPkg::wrEnRc;
                busSel  = ctrlPkg::busAc;
            end
            ctrlPkg::MvRAc: begin
                wrEnReg = ctrlPkg::wrEnR;
                busSel  = ctrlPkg::busAc;
            end
            ctrlPkg::MvR1Ac: begin
                wrEnReg = ctrlPkg::wrEnR1;
                busSel  = ctrlPkg::busAc;
            end
            ctrlPkg::MvAcRp, ctrlPkg::MvAcRq, ctrlPkg::MvAcRl: begin
                aluOp   = ctrlPkg::aluPass;
                wrEnReg = ctrlPkg::wrEnAc;
                zWrEn   = 1'b1;
                busSel  = (state == ctrlPkg::MvAcRp) ? ctrlPkg::busRp :
                          (state == ctrlPkg::MvAcRq) ? ctrlPkg::busRq : ctrlPkg::busRl;
            end
            ctrlPkg::Halt: begin
                busSel = ctrlPkg::busDMem;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/controlUnit.sv
`default_nettype none

`include "ctrl_settings.svh"

module controlUnit #(
    parameter int MEM_LATENCY = `CTRL_MEM_LATENCY
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  ctrlPkg::instrOp_t instruction,
    input  logic              zOut,
    output ctrlPkg::aluOp_t   aluOp,
    output ctrlPkg::incReg_t  incReg,
    output ctrlPkg::wrEnReg_t wrEnReg,
    output ctrlPkg::busSel_t  busSel,
    output logic              dataMemWrEn,
    output logic              zWrEn,
    output logic              done,
    output logic              ready
);

    ctrlPkg::ctrlState_t state;
    logic                memStep;
    logic                memStepLast;

    instrSequencer instrSequencer_i (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .instruction (instruction),
        .zOut        (zOut),
        .memStepLast (memStepLast),
        .state       (state),
        .memStep     (memStep),
        .done        (done),
        .ready       (ready)
    );

    memStepTimer #(
        .MEM_LATENCY (MEM_LATENCY)
    ) memStepTimer_i (
        .clk         (clk),
        .rstN        (rstN),
        .memStep     (memStep),
        .memStepLast (memStepLast)
    );

    controlDecoder controlDecoder_i (
        .state       (state),
        .aluOp       (aluOp),
        .incReg      (incReg),
        .wrEnReg     (wrEnReg),
        .busSel      (busSel),
        .dataMemWrEn (dataMemWrEn),
        .zWrEn       (zWrEn)
    );

endmodule

`default_nettype wire

//--- verif/controlUnitTb.sv
`default_nettype none

`include "ctrl_settings.svh"

module controlUnitTb;

    localparam int MEM_CYCLES     = `CTRL_MEM_LATENCY + 1;   // length of every memory step
    localparam int HALT_CYCLES    = 10;
    localparam int NUM_ROWS       = 27;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (3 * MEM_CYCLES + 3) + 50;

    typedef struct packed {
        ctrlPkg::aluOp_t   alu;
        ctrlPkg::incReg_t  inc;
        ctrlPkg::wrEnReg_t wr;
        ctrlPkg::busSel_t  bus;
        logic              memWr;
        logic              zWr;
        logic              rdy;
        logic              dn;
        int                cycles;
    } step_t;

    typedef struct packed {
        ctrlPkg::instrOp_t op;
        logic              z;
        logic              useRand;   // zOut taken from $random instead of z
    } row_t;

    logic              clk;
    logic              rstN;
    logic              start;
    ctrlPkg::instrOp_t instruction;
    logic              zOut;
    ctrlPkg::aluOp_t   aluOp;
    ctrlPkg::incReg_t  incReg;
    ctrlPkg::wrEnReg_t wrEnReg;
    ctrlPkg::busSel_t  busSel;
    logic              dataMemWrEn;
    logic              zWrEn;
    logic              done;
    logic              ready;

    step_t steps[$];
    int    seed       = 36;
    int    cycleCount = 0;

    row_t testRows [NUM_ROWS] = '{
        '{ctrlPkg::NOP, 1'b0, 1'b1},      '{ctrlPkg::CLAC, 1'b0, 1'b1},
        '{ctrlPkg::LDIAC, 1'b0, 1'b0},    '{ctrlPkg::LDAC, 1'b0, 1'b0},
        '{ctrlPkg::STR, 1'b0, 1'b0},      '{ctrlPkg::STIR, 1'b0, 1'b0},
        '{ctrlPkg::JUMP, 1'b1, 1'b0},     '{ctrlPkg::JMPNZ, 1'b0, 1'b0},
        '{ctrlPkg::JMPNZ, 1'b1, 1'b0},    '{ctrlPkg::JMPZ, 1'b1, 1'b0},
        '{ctrlPkg::JMPZ, 1'b0, 1'b0},     '{ctrlPkg::MUL, 1'b0, 1'b1},
        '{ctrlPkg::ADD, 1'b0, 1'b1},      '{ctrlPkg::SUB, 1'b0, 1'b1},
        '{ctrlPkg::INCAC, 1'b0, 1'b1},    '{ctrlPkg::MV_RL_AC, 1'b0, 1'b1},
        '{ctrlPkg::MV_RP_AC, 1'b0, 1'b1}, '{ctrlPkg::MV_RQ_AC, 1'b0, 1'b1},
        '{ctrlPkg::MV_RC_AC, 1'b0, 1'b1}, '{ctrlPkg::MV_R_AC, 1'b0, 1'b1},
        '{ctrlPkg::MV_R1_AC, 1'b0, 1'b1}, '{ctrlPkg::MV_AC_RP, 1'b0, 1'b1},
        '{ctrlPkg::MV_AC_RQ, 1'b0, 1'b1}, '{ctrlPkg::MV_AC_RL, 1'b0, 1'b1},
        '{ctrlPkg::instrOp_t'(8'd200), 1'b0, 1'b0},   // not an opcode
        '{ctrlPkg::ADD, 1'b0, 1'b1},      '{ctrlPkg::ENDOP, 1'b0, 1'b0}
    };

    controlUnit #(
        .MEM_LATENCY (`CTRL_MEM_LATENCY)
    ) controlUnit_i (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .instruction (instruction),
        .zOut        (zOut),
        .aluOp       (aluOp),
        .incReg      (incReg),
        .wrEnReg     (wrEnReg),
        .busSel      (busSel),
        .dataMemWrEn (dataMemWrEn),
        .zWrEn       (zWrEn),
        .done        (done),
        .ready       (ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            abortRun($sformatf("timeout: run still busy after %0d cycles", cycleCount));
        end
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkAluOp(input string sigName, input ctrlPkg::aluOp_t expVal,
                              input ctrlPkg::aluOp_t actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("mismatch at %0t: %s expected %s got %s (%0d)",
                               $time, sigName, expVal.name(), actVal.name(), actVal));
        end
    endtask

    task automatic checkIncReg(input string sigName, input ctrlPkg::incReg_t expVal,
                               input ctrlPkg::incReg_t actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("mismatch at %0t: %s expected %b got %b",
                               $time, sigName, expVal, actVal));
        end
    endtask

    task automatic checkWrEnReg(input string sigName, input ctrlPkg::wrEnReg_t expVal,
                                input ctrlPkg::wrEnReg_t actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("mismatch at %0t: %s expected %b got %b",
                               $time, sigName, expVal, actVal));
        end
    endtask

    task automatic checkBusSel(input string sigName, input ctrlPkg::busSel_t expVal,
                               input ctrlPkg::busSel_t actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("mismatch at %0t: %s expected %s got %s (%0d)",
                               $time, sigName, expVal.name(), actVal.name(), actVal));
        end
    endtask

    task automatic checkBit(input string sigName, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            abortRun($sformatf("mismatch at %0t: %s expected %b got %b",
                               $time, sigName, expVal, actVal));
        end
    endtask

    function automatic step_t ctlStep(input ctrlPkg::incReg_t inc, input ctrlPkg::wrEnReg_t wr,
                                      input ctrlPkg::busSel_t bus, input int cycles);
        step_t s;
        s.alu    = ctrlPkg::aluIdle;
        s.inc    = inc;
        s.wr     = wr;
        s.bus    = bus;
        s.memWr  = 1'b0;
        s.zWr    = 1'b0;
        s.rdy    = 1'b0;
        s.dn     = 1'b0;
        s.cycles = cycles;
        return s;
    endfunction

    // ALU result into AC with the zero flag updated
    function automatic step_t acStep(input ctrlPkg::aluOp_t alu, input ctrlPkg::busSel_t bus,
                                     input int cycles);
        step_t s;
        s     = ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnAc, bus, cycles);
        s.alu = alu;
        s.zWr = 1'b1;
        return s;
    endfunction

    function automatic step_t idleStep(input int cycles);
        step_t s;
        s     = ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnNone, ctrlPkg::busIdle, cycles);
        s.rdy = 1'b1;
        return s;
    endfunction

    // expected control words of one instruction from its fetch on
    task automatic buildSteps(input ctrlPkg::instrOp_t op, input logic z);
        step_t             s;
        logic              taken;
        ctrlPkg::wrEnReg_t mvReg;
        steps.delete();
        steps.push_back(ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnIr, ctrlPkg::busIdle, MEM_CYCLES));
        steps.push_back(ctlStep(ctrlPkg::incPc, ctrlPkg::wrEnNone, ctrlPkg::busDMem, 1));
        taken = (op == ctrlPkg::JUMP) || ((op == ctrlPkg::JMPZ) == z);   // JMPZ on 1 and JMPNZ on 0
        mvReg = ctrlPkg::wrEnNone;
        case (op)
            ctrlPkg::NOP:      steps.push_back(ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnNone,
                                                       ctrlPkg::busIdle, 1));
            ctrlPkg::ENDOP: begin
                s     = ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnNone, ctrlPkg::busDMem, HALT_CYCLES);
                s.dn  = 1'b1;
                steps.push_back(s);
            end
            ctrlPkg::CLAC:     steps.push_back(acStep(ctrlPkg::aluClr, ctrlPkg::busIdle, 1));
            ctrlPkg::LDIAC, ctrlPkg::STIR: begin
                steps.push_back(ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnIr, ctrlPkg::busIdle,
                                        MEM_CYCLES));
                steps.push_back(ctlStep(ctrlPkg::incPc, ctrlPkg::wrEnAr, ctrlPkg::busIr, 1));
            end
            ctrlPkg::LDAC, ctrlPkg::STR: begin
                steps.push_back(ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnAr, ctrlPkg::busAc, 1));
            end
            ctrlPkg::JUMP, ctrlPkg::JMPNZ, ctrlPkg::JMPZ: begin
                if (taken) begin
                    steps.push_back(ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnIr, ctrlPkg::busDMem,
                                            MEM_CYCLES));
                    steps.push_back(ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnPc, ctrlPkg::busIr,
                                            1));
                end else begin
                    steps.push_back(ctlStep(ctrlPkg::incPc, ctrlPkg::wrEnNone, ctrlPkg::busIdle,
                                            1));
                end
            end
            ctrlPkg::MUL: begin
                s     = acStep(ctrlPkg::aluMul, ctrlPkg::busR1, 1);
                s.inc = ctrlPkg::incRcRpRq;
                steps.push_back(s);
            end
            ctrlPkg::ADD:      steps.push_back(acStep(ctrlPkg::aluAdd, ctrlPkg::busR, 1));
            ctrlPkg::SUB:      steps.push_back(acStep(ctrlPkg::aluSub, ctrlPkg::busRc, 1));
            ctrlPkg::INCAC:    steps.push_back(acStep(ctrlPkg::aluInc, ctrlPkg::busIdle, 1));
            ctrlPkg::MV_RL_AC: mvReg = ctrlPkg::wrEnRl;
            ctrlPkg::MV_RP_AC: mvReg = ctrlPkg::wrEnRp;
            ctrlPkg::MV_RQ_AC: mvReg = ctrlPkg::wrEnRq;
            ctrlPkg::MV_RC_AC: mvReg = ctrlPkg::wrEnRc;
            ctrlPkg::MV_R_AC:  mvReg = ctrlPkg::wrEnR;
            ctrlPkg::MV_R1_AC: mvReg = ctrlPkg::wrEnR1;
            ctrlPkg::MV_AC_RP: steps.push_back(acStep(ctrlPkg::aluPass, ctrlPkg::busRp, 1));
            ctrlPkg::MV_AC_RQ: steps.push_back(acStep(ctrlPkg::aluPass, ctrlPkg::busRq, 1));
            ctrlPkg::MV_AC_RL: steps.push_back(acStep(ctrlPkg::aluPass, ctrlPkg::busRl, 1));
            default:           steps.push_back(idleStep(1));   // unknown opcode back to Idle
        endcase
        if (mvReg != ctrlPkg::wrEnNone) begin
            steps.push_back(ctlStep(ctrlPkg::incNone, mvReg, ctrlPkg::busAc, 1));
        end
        // memory access that closes loads and stores
        if (op == ctrlPkg::LDIAC || op == ctrlPkg::LDAC) begin
            steps.push_back(acStep(ctrlPkg::aluPass, ctrlPkg::busDMem, MEM_CYCLES));
        end else if (op == ctrlPkg::STIR || op == ctrlPkg::STR) begin
            s       = ctlStep(ctrlPkg::incNone, ctrlPkg::wrEnNone, ctrlPkg::busIdle, MEM_CYCLES);
            s.memWr = 1'b1;
            steps.push_back(s);
        end
    endtask

    task automatic checkStep(input step_t s);
        repeat (s.cycles) begin
            @(negedge clk);
            checkAluOp("aluOp", s.alu, aluOp);
            checkIncReg("incReg", s.inc, incReg);
            checkWrEnReg("wrEnReg", s.wr, wrEnReg);
            checkBusSel("busSel", s.bus, busSel);
            checkBit("dataMemWrEn", s.memWr, dataMemWrEn);
            checkBit("zWrEn", s.zWr, zWrEn);
            checkBit("ready", s.rdy, ready);
            checkBit("done", s.dn, done);
            @(posedge clk);
        end
    endtask

    initial begin
        int   randWord;
        logic zVal;
        rstN        <= 1'b0;
        start       <= 1'b0;
        instruction <= ctrlPkg::NOP;
        zOut        <= 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        checkStep(idleStep(5));      // start still low
        start <= 1'b1;               // stays high for the rest of the program
        checkStep(idleStep(1));
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (testRows[i].useRand) begin
                randWord = $random(seed);
                zVal     = randWord[0];
            end else begin
                zVal = testRows[i].z;
            end
            instruction <= testRows[i].op;   // sampled later in Decode
            zOut        <= zVal;
            buildSteps(testRows[i].op, zVal);
            foreach (steps[j]) begin
                checkStep(steps[j]);
            end
        end
        rstN  <= 1'b0;                       // only reset leaves Halt
        start <= 1'b0;
        @(posedge clk);
        checkStep(idleStep(2));
        rstN <= 1'b1;
        checkStep(idleStep(3));
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
hdl/ctrlPkg.sv
hdl/memStepTimer.sv
hdl/instrSequencer.sv
hdl/controlDecoder.sv
hdl/controlUnit.sv
verif/controlUnitTb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= controlUnitTb
LINT_TOP   ?= controlUnit
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
